// ==== uartTop.f ====
hw/uartPkg.sv
hw/baudGen.sv
hw/uartFifo.sv
hw/uartTrans.sv
hw/uartRecv.sv
hw/uartTop.sv
verif/uartTrans_properties.sv
verif/uartTopTb.sv

// ==== verif/uartCases.txt ====
# columns: name op count expRecv expFull bytes (hex, random fill past the listed ones)
# op idle watches line and flags for count cycles, send writes one byte, burst writes count bytes
resetIdle   idle  20  0  0
sendA5      send  1   1  0  a5
send00      send  1   1  0  00
sendFf      send  1   1  0  ff
send5a      send  1   1  0  5a
send81      send  1   1  0  81
send7e      send  1   1  0  7e
burstFour   burst 4   4  0  12 34 56 78
burstRand   burst 3   3  0  c3
burstEight  burst 8   8  0  01 80 55
fullTx      burst 18  17 1
sendAfter   send  1   1  0  3c
idleAfter   idle  50  0  0

// ==== verif/uartTopTb.sv ====
/* UART subsystem testbench
   runs the cases file through a tx to rx loopback, checks line, flags and data */
`timescale 1ns/1ps

module uartTopTb;

	localparam int dvsr = 4;
	localparam int bitCycles = 16 * dvsr;   // clk cycles per bit
	localparam int waitLimit = 4000;        // cycles for several frames
	localparam int quietCycles = 1500;      // over two frames
	localparam int maxBytes = 32;

	logic       clk;
	logic       reset;
	logic       wrUart;
	logic [7:0] wData;
	logic       txFull;
	logic       rdUart;
	logic [7:0] rData;
	logic       rxEmpty;
	logic       serialLine;   // tx looped back to rx

	int         errorCount;
	int         timeoutCount;
	logic [7:0] caseBytes [maxBytes];   // bytes of the current case
	logic [7:0] sentQ [$];              // expected arrivals in order

	uartTop #(
		.dvsr(dvsr)
	) dut_i (
		.clk(clk),
		.reset(reset),
		.wrUart(wrUart),
		.wData(wData),
		.txFull(txFull),
		.rdUart(rdUart),
		.rData(rData),
		.rxEmpty(rxEmpty),
		.tx(serialLine),
		.rx(serialLine)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;   // 100 ns period
	end

	//////////////////////////////////////////////////
	// host side tasks
	//////////////////////////////////////////////////

	// back-to-back writes at one per cycle
	task automatic writeAll(input int n);
		int i;
		for (i = 0; i < n; i++)
		begin
			@(posedge clk);
			wrUart <= 1'b1;
			wData  <= caseBytes[i];
		end
		@(posedge clk);
		wrUart <= 1'b0;
	endtask

	task automatic receiveBytes(input string caseName, input int n);
		int         i;
		int         waited;
		logic [7:0] expByte;
		for (i = 0; i < n; i++)
		begin
			waited = 0;
			@(negedge clk);
			while (rxEmpty && waited < waitLimit)
			begin
				@(negedge clk);
				waited++;
			end
			if (rxEmpty)
			begin
				$display("timeout in case %s: byte %0d never reached the receive FIFO",
					caseName, i);
				timeoutCount++;
				return;
			end
			expByte = sentQ.pop_front();
			if (rData !== expByte)
			begin
				$display("FAILED %s: rData byte %0d expected %h, actual %h",
					caseName, i, expByte, rData);
				errorCount++;
			end
			@(posedge clk);
			rdUart <= 1'b1;   // pop head
			@(posedge clk);
			rdUart <= 1'b0;
			@(negedge clk);
			if (rxEmpty !== 1'b1)
			begin
				$display("FAILED %s: rxEmpty after read expected %b, actual %b",
					caseName, 1'b1, rxEmpty);
				errorCount++;
			end
		end
	endtask

	//////////////////////////////////////////////////
	// line side checks
	//////////////////////////////////////////////////

	// mid-bit samples of one frame from the start bit on
	task automatic checkFrame(input string caseName, input logic [7:0] value);
		int         waited;
		int         k;
		logic [9:0] expBits;
		expBits = {1'b1, value, 1'b0};   // stop, data, start
		waited = 0;
		@(negedge clk);
		while (serialLine !== 1'b0 && waited < waitLimit)
		begin
			@(negedge clk);
			waited++;
		end
		if (serialLine !== 1'b0)
		begin
			$display("timeout in case %s: tx never dropped for a start bit", caseName);
			timeoutCount++;
		end
		else
		begin
			repeat (bitCycles / 2) @(negedge clk);   // to mid start bit
			for (k = 0; k < 10; k++)
			begin
				if (serialLine !== expBits[k])
				begin
					$display("FAILED %s: tx bit %0d expected %b, actual %b",
						caseName, k, expBits[k], serialLine);
					errorCount++;
				end
				if (k < 9)
					repeat (bitCycles) @(negedge clk);
			end
		end
	endtask

	task automatic checkIdle(input string caseName, input int n);
		int i;
		bit bad;
		bad = 1'b0;
		for (i = 0; i < n; i++)
		begin
			@(negedge clk);
			if (!bad && (serialLine !== 1'b1 || txFull !== 1'b0 || rxEmpty !== 1'b1))
			begin
				$display("FAILED %s: tx/txFull/rxEmpty expected 1/0/1, actual %b/%b/%b",
					caseName, serialLine, txFull, rxEmpty);
				errorCount++;
				bad = 1'b1;   // one report per case
			end
		end
	endtask

	// nothing beyond the expected bytes may show up
	task automatic checkQuiet(input string caseName);
		int i;
		bit seen;
		seen = 1'b0;
		for (i = 0; i < quietCycles; i++)
		begin
			@(negedge clk);
			if (!rxEmpty)
				seen = 1'b1;
		end
		if (seen)
		begin
			$display("case %s: an extra byte arrived in the receive FIFO", caseName);
			errorCount++;
		end
	endtask

	task automatic runCase(input string caseName, input string op, input int count,
		input int expRecv, input int expFull);
		int i;
		sentQ.delete();
		if (op == "idle")
			checkIdle(caseName, count);
		else if (op == "send" || op == "burst")
		begin
			for (i = 0; i < expRecv; i++)
				sentQ.push_back(caseBytes[i]);   // queued in write order up to what fits
			writeAll(count);
			@(negedge clk);
			if (txFull !== expFull[0])
			begin
				$display("FAILED %s: txFull expected %b, actual %b",
					caseName, expFull[0], txFull);
				errorCount++;
			end
			if (op == "send")
				checkFrame(caseName, caseBytes[0]);
			receiveBytes(caseName, expRecv);
			checkQuiet(caseName);
		end
		else
		begin
			$display("case %s has an unknown operation %s", caseName, op);
			errorCount++;
		end
	endtask

	//////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////

	initial
	begin
		int    fd;
		int    nItems;
		int    count;
		int    expRecv;
		int    expFull;
		int    i;
		string lineStr;
		string caseName;
		string op;
		reset        = 1'b1;
		wrUart       = 1'b0;
		wData        = '0;
		rdUart       = 1'b0;
		errorCount   = 0;
		timeoutCount = 0;
		void'($urandom(78));   // fixed seed for fill bytes
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		fd = $fopen("verif/uartCases.txt", "r");
		if (fd == 0)
		begin
			$display("could not open the cases file verif/uartCases.txt");
			errorCount++;
		end
		else
		begin
			while (!$feof(fd))
			begin
				lineStr = "";
				nItems = $fgets(lineStr, fd);
				if (lineStr.len() == 0 || lineStr.getc(0) == "#")
					continue;   // blank or column notes
				nItems = $sscanf(lineStr, "%s %s %d %d %d %h %h %h %h", caseName, op,
					count, expRecv, expFull, caseBytes[0], caseBytes[1], caseBytes[2],
					caseBytes[3]);
				if (nItems < 5)
					continue;
				if (count > maxBytes || expRecv > count)
				begin
					$display("case %s asks for more bytes than it can hold", caseName);
					errorCount++;
					continue;
				end
				for (i = nItems - 5; i < count; i++)
					caseBytes[i] = 8'($urandom());   // fill past listed bytes
				runCase(caseName, op, count, expRecv, expFull);
			end
			$fclose(fd);
		end
		$display("errors: %0d check failures, %0d timeouts", errorCount, timeoutCount);
		if (errorCount == 0 && timeoutCount == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// ==== verif/uartTrans_properties.sv ====
/* transmitter assertions
   line level and FIFO pop strobe of the UART transmitter */
`timescale 1ns/1ps

module uartTransProperties (
	input logic       clk,
	input logic       reset,
	input logic       txStart,
	input logic       tx,
	input logic       txDoneTick,
	input logic [1:0] state
);

	localparam logic [1:0] idleState = 2'b00;   // transmitter idle encoding

	// line rests high between frames
	idleHigh: assert property (@(posedge clk) disable iff (reset)
		(state == idleState) |-> tx)
		else $error("tx low while transmitter is idle");

	// pop strobe only on the way out of idle
	doneInIdle: assert property (@(posedge clk) disable iff (reset)
		txDoneTick |-> (state == idleState))
		else $error("txDoneTick pulsed outside idle");

	doneNeedsStart: assert property (@(posedge clk) disable iff (reset)
		!txStart |-> !txDoneTick)
		else $error("txDoneTick pulsed without txStart");

	// start bit right after leaving idle
	startBitLow: assert property (@(posedge clk) disable iff (reset)
		((state == idleState) && txStart) |=> !tx)
		else $error("tx not low one cycle after leaving idle");

endmodule

bind uartTrans uartTransProperties uartTransProperties_i (
	.clk(clk),
	.reset(reset),
	.txStart(txStart),
	.tx(tx),
	.txDoneTick(txDoneTick),
	.state(stateReg)
);

// ==== hw/uartTop.sv ====
/* UART subsystem top
   tick generator, transmit and receive FIFOs, transmitter and receiver */
`timescale 1ns/1ps

module uartTop #(
	parameter int dvsr = uartPkg::dvsrDefault,
	parameter int dataBits = uartPkg::dataBitsDefault,
	parameter int sbTick = uartPkg::sbTickDefault,
	parameter int fifoAddrWidth = uartPkg::fifoAddrWidthDefault
) (
	input  logic                clk,
	input  logic                reset,
	// host side
	input  logic                wrUart,
	input  logic [dataBits-1:0] wData,
	output logic                txFull,
	input  logic                rdUart,
	output logic [dataBits-1:0] rData,
	output logic                rxEmpty,
	// line side
	output logic                tx,
	input  logic                rx
);

	logic                sTick;        // oversampling tick
	logic [dataBits-1:0] txFifoOut;    // head of transmit FIFO
	logic                txEmpty;
	logic                txDoneTick;   // transmitter took the head
	logic [dataBits-1:0] rxDout;
	logic                rxDoneTick;

	baudGen #(
		.dvsr(dvsr)
	) baudGen_i (
		.clk(clk),
		.reset(reset),
		.sTick(sTick)
	);

	//////////////////////////////////////////////////
	// transmit path
	//////////////////////////////////////////////////

	uartFifo #(
		.dataBits(dataBits),
		.fifoAddrWidth(fifoAddrWidth)
	) txFifo_i (
		.clk(clk),
		.reset(reset),
		.wr(wrUart),
		.rd(txDoneTick),     // popped as the frame starts
		.wData(wData),
		.rData(txFifoOut),
		.full(txFull),
		.empty(txEmpty)
	);

	uartTrans #(
		.dataBits(dataBits),
		.sbTick(sbTick)
	) uartTrans_i (
		.clk(clk),
		.reset(reset),
		.sTick(sTick),
		.txStart(~txEmpty),  // anything queued starts a frame
		.din(txFifoOut),
		.tx(tx),
		.txDoneTick(txDoneTick)
	);

	//////////////////////////////////////////////////
	// receive path
	//////////////////////////////////////////////////

	uartRecv #(
		.dataBits(dataBits),
		.sbTick(sbTick)
	) uartRecv_i (
		.clk(clk),
		.reset(reset),
		.sTick(sTick),
		.rx(rx),
		.rxDout(rxDout),
		.rxDoneTick(rxDoneTick)
	);

	// full flag unused, a byte arriving on a full FIFO is dropped there
	uartFifo #(
		.dataBits(dataBits),
		.fifoAddrWidth(fifoAddrWidth)
	) rxFifo_i (
		.clk(clk),
		.reset(reset),
		.wr(rxDoneTick),
		.rd(rdUart),
		.wData(rxDout),
		.rData(rData),
		.full(),
		.empty(rxEmpty)
	);

endmodule

// ==== hw/uartRecv.sv ====
/* UART receiver
   finds the start bit on rx, samples each bit mid-period and assembles the byte */
`timescale 1ns/1ps

module uartRecv #(
	parameter int dataBits = uartPkg::dataBitsDefault,
	parameter int sbTick = uartPkg::sbTickDefault
) (
	input  logic                clk,
	input  logic                reset,
	input  logic                sTick,
	input  logic                rx,
	output logic [dataBits-1:0] rxDout,
	output logic                rxDoneTick
);
	import uartPkg::*;

	localparam int sMax = (sbTick > oversample) ? sbTick : oversample;
	localparam int sWidth = $clog2(sMax);
	localparam int nWidth = $clog2(dataBits);

	localparam logic [sWidth-1:0] midStart = sWidth'(oversample / 2 - 1);   // 7 ticks in
	localparam logic [sWidth-1:0] bitLast = sWidth'(oversample - 1);
	localparam logic [sWidth-1:0] stopLast = sWidth'(sbTick - 1);
	localparam logic [nWidth-1:0] nLast = nWidth'(dataBits - 1);

	localparam logic [1:0] idle  = 2'b00;
	localparam logic [1:0] start = 2'b01;
	localparam logic [1:0] data  = 2'b10;
	localparam logic [1:0] stop  = 2'b11;

	logic                rxMeta, rxSync;    // two-flop synchronizer
	logic [1:0]          stateReg, stateNext;
	logic [sWidth-1:0]   sReg, sNext;       // ticks since last sample point
	logic [nWidth-1:0]   nReg, nNext;       // data bits received
	logic [dataBits-1:0] bReg, bNext;       // assembled byte

	//////////////////////////////////////////////////
	// registers
	//////////////////////////////////////////////////

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			rxMeta   <= 1'b1;   // idle level, no false start
			rxSync   <= 1'b1;
			stateReg <= idle;
			sReg     <= '0;
			nReg     <= '0;
		end
		else
		begin
			rxMeta   <= rx;
			rxSync   <= rxMeta;
			stateReg <= stateNext;
			sReg     <= sNext;
			nReg     <= nNext;
		end
	end

	always_ff @(posedge clk)
	begin
		bReg <= bNext;
	end

	//////////////////////////////////////////////////
	// next state
	//////////////////////////////////////////////////

	always_comb
	begin
		stateNext  = stateReg;
		sNext      = sReg;
		nNext      = nReg;
		bNext      = bReg;
		rxDoneTick = 1'b0;
		case (stateReg)
			idle:
			begin
				if (!rxSync)   // falling edge
				begin
					sNext     = '0;
					stateNext = start;
				end
			end
			start:
			begin
				if (sTick)
				begin
					if (sReg == midStart)
					begin
						sNext = '0;
						nNext = '0;
						// still low at mid-bit, real start bit
						stateNext = rxSync ? idle : data;
					end
					else
						sNext = sReg + 1'b1;
				end
			end
			data:
			begin
				if (sTick)
				begin
					if (sReg == bitLast)
					begin
						sNext = '0;
						bNext = {rxSync, bReg[dataBits-1:1]};   // LSB arrives first
						if (nReg == nLast)
							stateNext = stop;
						else
							nNext = nReg + 1'b1;
					end
					else
						sNext = sReg + 1'b1;
				end
			end
			default:   // stop
			begin
				if (sTick)
				begin
					if (sReg == stopLast)
					begin
						rxDoneTick = 1'b1;   // byte ready for the FIFO
						stateNext  = idle;
					end
					else
						sNext = sReg + 1'b1;
				end
			end
		endcase
	end

	assign rxDout = bReg;

endmodule

// ==== hw/uartTrans.sv ====
/* UART transmitter
   four-state FSM sending start bit, data LSB first and stop bit on tx */
`timescale 1ns/1ps

module uartTrans #(
	parameter int dataBits = uartPkg::dataBitsDefault,
	parameter int sbTick = uartPkg::sbTickDefault
) (
	input  logic                clk,
	input  logic                reset,
	input  logic                sTick,
	input  logic                txStart,
	input  logic [dataBits-1:0] din,
	output logic                tx,
	output logic                txDoneTick
);
	import uartPkg::*;

	// tick counter must reach the longer of a data bit and the stop bit
	localparam int sMax = (sbTick > oversample) ? sbTick : oversample;
	localparam int sWidth = $clog2(sMax);
	localparam int nWidth = $clog2(dataBits);

	localparam logic [sWidth-1:0] bitLast = sWidth'(oversample - 1);
	localparam logic [sWidth-1:0] stopLast = sWidth'(sbTick - 1);
	localparam logic [nWidth-1:0] nLast = nWidth'(dataBits - 1);

	// state encoding
	localparam logic [1:0] idle  = 2'b00;
	localparam logic [1:0] start = 2'b01;
	localparam logic [1:0] data  = 2'b10;
	localparam logic [1:0] stop  = 2'b11;

	logic [1:0]          stateReg, stateNext;
	logic [sWidth-1:0]   sReg, sNext;       // ticks within current bit
	logic [nWidth-1:0]   nReg, nNext;       // data bits sent
	logic [dataBits-1:0] bReg, bNext;       // shift register, LSB goes out
	logic                txReg, txNext;     // registered line, no glitches

	//////////////////////////////////////////////////
	// registers
	//////////////////////////////////////////////////

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			stateReg <= idle;
			sReg     <= '0;
			nReg     <= '0;
			txReg    <= 1'b1;   // line idles high
		end
		else
		begin
			stateReg <= stateNext;
			sReg     <= sNext;
			nReg     <= nNext;
			txReg    <= txNext;
		end
	end

	always_ff @(posedge clk)
	begin
		bReg <= bNext;   // payload only
	end

	//////////////////////////////////////////////////
	// next state
	//////////////////////////////////////////////////

	always_comb
	begin
		stateNext  = stateReg;
		sNext      = sReg;
		nNext      = nReg;
		bNext      = bReg;
		txNext     = txReg;
		txDoneTick = 1'b0;
		case (stateReg)
			idle:
			begin
				txNext = 1'b1;
				if (txStart)
				begin
					txDoneTick = 1'b1;   // pops the FIFO
					txNext     = 1'b0;   // start bit from next cycle
					bNext      = din;    // grab head before the pop moves it
					sNext      = '0;
					stateNext  = start;
				end
			end
			start:
			begin
				txNext = 1'b0;
				if (sTick)
				begin
					if (sReg == bitLast)
					begin
						sNext     = '0;
						nNext     = '0;
						stateNext = data;
					end
					else
						sNext = sReg + 1'b1;
				end
			end
			data:
			begin
				txNext = bReg[0];
				if (sTick)
				begin
					if (sReg == bitLast)
					begin
						sNext = '0;
						bNext = bReg >> 1;   // next bit into position 0
						if (nReg == nLast)
							stateNext = stop;
						else
							nNext = nReg + 1'b1;
					end
					else
						sNext = sReg + 1'b1;
				end
			end
			default:   // stop
			begin
				txNext = 1'b1;
				if (sTick)
				begin
					if (sReg == stopLast)
						stateNext = idle;   // frame done
					else
						sNext = sReg + 1'b1;
				end
			end
		endcase
	end

	assign tx = txReg;

endmodule

// ==== hw/uartFifo.sv ====
/* UART byte FIFO
   first-word-fall-through register array, shared by transmit and receive paths */
`timescale 1ns/1ps

module uartFifo #(
	parameter int dataBits = uartPkg::dataBitsDefault,
	parameter int fifoAddrWidth = uartPkg::fifoAddrWidthDefault
) (
	input  logic                clk,
	input  logic                reset,
	input  logic                wr,
	input  logic                rd,
	input  logic [dataBits-1:0] wData,
	output logic [dataBits-1:0] rData,
	output logic                full,
	output logic                empty
);

	localparam int depth = 2 ** fifoAddrWidth;

	logic [dataBits-1:0]      memArr [depth];   // storage, no reset
	logic [fifoAddrWidth-1:0] wPtr;             // next slot to fill
	logic [fifoAddrWidth-1:0] rPtr;             // head entry
	logic [fifoAddrWidth-1:0] wPtrSucc;
	logic [fifoAddrWidth-1:0] rPtrSucc;
	logic                     fullReg;
	logic                     emptyReg;
	logic                     wrEn;
	logic                     rdEn;

	// qualified strobes
	assign rdEn = rd & ~emptyReg;               // pop on empty ignored
	assign wrEn = wr & (~fullReg | rd);         // full takes a write only with a pop

	assign wPtrSucc = wPtr + 1'b1;
	assign rPtrSucc = rPtr + 1'b1;

	//////////////////////////////////////////////////
	// storage
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (wrEn)
			memArr[wPtr] <= wData;
	end

	// head always visible, no read needed
	assign rData = memArr[rPtr];

	//////////////////////////////////////////////////
	// pointers and flags
	//////////////////////////////////////////////////

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wPtr     <= '0;
			rPtr     <= '0;
			fullReg  <= 1'b0;
			emptyReg <= 1'b1;   // starts empty
		end
		else
		begin
			case ({wrEn, rdEn})
				2'b01:   // read only
				begin
					rPtr    <= rPtrSucc;
					fullReg <= 1'b0;
					if (rPtrSucc == wPtr)
						emptyReg <= 1'b1;   // last entry gone
				end
				2'b10:   // write only
				begin
					wPtr     <= wPtrSucc;
					emptyReg <= 1'b0;
					if (wPtrSucc == rPtr)
						fullReg <= 1'b1;    // caught up with head
				end
				2'b11:   // both, occupancy unchanged
				begin
					wPtr <= wPtrSucc;
					rPtr <= rPtrSucc;
				end
				default: ;   // idle
			endcase
		end
	end

	assign full  = fullReg;
	assign empty = emptyReg;

endmodule

// ==== hw/baudGen.sv ====
/* baud tick generator
   divides clk down to the one-cycle oversampling tick */
`timescale 1ns/1ps

module baudGen #(
	parameter int dvsr = uartPkg::dvsrDefault
) (
	input  logic clk,
	input  logic reset,
	output logic sTick
);
	import uartPkg::*;

	// count value on which the counter wraps
	localparam logic [dvsrWidth-1:0] lastCount = dvsrWidth'(dvsr - 1);

	logic [dvsrWidth-1:0] countReg;   // free running, modulo dvsr

	//////////////////////////////////////////////////
	// divider
	//////////////////////////////////////////////////

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			countReg <= '0;
		end
		else if (countReg == lastCount)
		begin
			countReg <= '0;   // wrap
		end
		else
		begin
			countReg <= countReg + 1'b1;
		end
	end

	// one cycle wide, once every dvsr cycles
	assign sTick = (countReg == lastCount);

endmodule

// ==== hw/uartPkg.sv ====
/* UART constants
   default frame format, FIFO depth and baud tick settings */
package uartPkg;

	//////////////////////////////////////////////////
	// frame format
	//////////////////////////////////////////////////

	localparam int dataBitsDefault = 8;   // data bits per frame
	localparam int sbTickDefault = 16;    // ticks in stop bit, 16 for one stop bit
	localparam int oversample = 16;       // ticks per start or data bit

	//////////////////////////////////////////////////
	// buffering
	//////////////////////////////////////////////////

	// 4 address bits, so 16 entries per FIFO
	localparam int fifoAddrWidthDefault = 4;

	//////////////////////////////////////////////////
	// baud tick
	//////////////////////////////////////////////////

	localparam int dvsrDefault = 4;       // clk cycles per oversampling tick
	localparam int dvsrWidth = 8;         // tick counter width, dvsr up to 256

endpackage
